// File: common/spi_target_pkg.sv
/*
 * SPI target shared definitions
 * Byte and operand count types used between the SPI framing block
 * and the sub-peripherals, and the opcode map of the register bank,
 * byte FIFO and CRC-8 unit.
 */

package spi_target_pkg;

    // One SPI data byte
    typedef logic [7:0] byte_t;

    // Operand bytes completed in the current transaction, wraps around
    typedef logic [15:0] operand_count_t;

    // Register bank, low 3 bits carry the start address
    localparam byte_t OP_REG_WRITE_BASE = 8'h10;
    localparam byte_t OP_REG_READ_BASE  = 8'h18;

    // Byte FIFO
    localparam byte_t OP_FIFO_PUSH  = 8'h20;
    localparam byte_t OP_FIFO_POP   = 8'h21;
    localparam byte_t OP_FIFO_LEVEL = 8'h22;

    // CRC-8 unit
    localparam byte_t OP_CRC_FEED  = 8'h30;
    localparam byte_t OP_CRC_READ  = 8'h31;
    localparam byte_t OP_CRC_CLEAR = 8'h32;

endpackage

// File: spi_peripheral/spi_peripheral.sv
/*
 * SPI framing block
 * Synchronizes the SPI pins, captures one opcode byte followed by any
 * number of operand bytes (mode 0, MSB first), and strobes them to the
 * sub-peripherals. The highest-priority valid response is registered
 * and shifted back out during each operand byte.
 */

`timescale 1ns/1ps

module spi_peripheral import spi_target_pkg::*; (
    input  logic           clock_in,
    input  logic           arst_n,

    // External SPI pins
    input  logic           spi_select,
    input  logic           spi_clock,
    input  logic           spi_data_in,
    output logic           spi_data_out,

    // Towards the sub-peripherals
    output byte_t          opcode,
    output byte_t          operand,
    output logic           opcode_valid,
    output logic           operand_valid,
    output operand_count_t operand_count,

    // Responses, highest priority first
    input  byte_t          response_1,
    input  byte_t          response_2,
    input  byte_t          response_3,
    input  logic           response_1_valid,
    input  logic           response_2_valid,
    input  logic           response_3_valid
);

    logic  select_meta;
    logic  clock_meta;
    logic  data_meta;
    logic  select_sync;
    logic  clock_sync;
    logic  data_sync;
    logic  clock_sync_last;
    logic  clock_rise;

    // 15..8 while the opcode arrives, then 7..0 for every operand byte
    logic [3:0] bit_index;

    byte_t selected_response;
    byte_t response_reg;
    logic  data_out_reg;

    assign clock_rise = clock_sync & ~clock_sync_last;

    // Fixed priority among the sub-peripheral responses
    always_comb begin
        if (response_1_valid) begin
            selected_response = response_1;
        end else if (response_2_valid) begin
            selected_response = response_2;
        end else if (response_3_valid) begin
            selected_response = response_3;
        end else begin
            selected_response = 8'h00;
        end
    end

    // Two-flop synchronizer plus edge history
    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            select_meta     <= 1'b1;
            clock_meta      <= 1'b0;
            data_meta       <= 1'b0;
            select_sync     <= 1'b1;
            clock_sync      <= 1'b0;
            data_sync       <= 1'b0;
            clock_sync_last <= 1'b0;
        end else begin
            select_meta     <= spi_select;
            clock_meta      <= spi_clock;
            data_meta       <= spi_data_in;
            select_sync     <= select_meta;
            clock_sync      <= clock_meta;
            data_sync       <= data_meta;
            clock_sync_last <= clock_sync;
        end
    end

    // Framing state; select high ends the transaction
    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            bit_index     <= 4'd15;
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
            operand_count <= '0;
            response_reg  <= 8'h00;
            data_out_reg  <= 1'b0;
        end else if (select_sync) begin
            bit_index     <= 4'd15;
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
            operand_count <= '0;
            response_reg  <= 8'h00;
            data_out_reg  <= 1'b0;
        end else begin
            operand_valid <= 1'b0;
            response_reg  <= selected_response;

            // Reply bits only during operand bytes
            if (bit_index < 4'd8) begin
                data_out_reg <= response_reg[bit_index[2:0]];
            end else begin
                data_out_reg <= 1'b0;
            end

            if (clock_rise) begin
                if (bit_index == 4'd8) begin
                    opcode_valid <= 1'b1;
                end

                // Last bit of a byte wraps back to 7 for the next operand
                if (bit_index == 4'd0) begin
                    operand_valid <= 1'b1;
                    operand_count <= operand_count + 16'd1;
                    bit_index     <= 4'd7;
                end else begin
                    bit_index <= bit_index - 4'd1;
                end
            end
        end
    end

    // Opcode and operand shift registers
    always_ff @(posedge clock_in) begin
        if (clock_rise && !select_sync) begin
            if (bit_index > 4'd7) begin
                opcode[bit_index[2:0]] <= data_sync;
            end else begin
                operand[bit_index[2:0]] <= data_sync;
            end
        end
    end

    // Idle line stays low while deselected
    assign spi_data_out = data_out_reg & ~spi_select;

endmodule

// File: source/register_bank.sv
/*
 * Register bank
 * Eight byte registers accessed in bursts. The opcode carries the start
 * address and each operand byte moves to the next address, wrapping
 * modulo 8, for both writes and reads.
 */

`timescale 1ns/1ps

module register_bank import spi_target_pkg::*; (
    input  logic           clock_in,
    input  logic           arst_n,

    input  byte_t          opcode,
    input  logic           opcode_valid,
    input  byte_t          operand,
    input  logic           operand_valid,
    input  operand_count_t operand_count,

    output byte_t          response,
    output logic           response_valid
);

    byte_t      regs [8];

    logic       is_write;
    logic       is_read;
    logic [2:0] start_addr;
    logic [2:0] read_addr;
    logic [2:0] write_addr;

    // Opcode decode on the upper five bits
    assign is_write = opcode_valid && (opcode[7:3] == OP_REG_WRITE_BASE[7:3]);
    assign is_read  = opcode_valid && (opcode[7:3] == OP_REG_READ_BASE[7:3]);

    assign start_addr = opcode[2:0];

    // Count already includes the byte being written
    assign write_addr = start_addr + operand_count[2:0] - 3'd1;

    // Count of completed bytes selects the one being shifted out
    assign read_addr  = start_addr + operand_count[2:0];

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (is_write && operand_valid) begin
            regs[write_addr] <= operand;
        end
    end

    // Writes reply with zero
    always_comb begin
        response_valid = is_write || is_read;
        if (is_read) begin
            response = regs[read_addr];
        end else begin
            response = 8'h00;
        end
    end

endmodule

// File: source/byte_fifo.sv
/*
 * Byte FIFO
 * Circular buffer with read and write pointers and a fill counter.
 * Push stores operand bytes and drops them when full, pop presents the
 * head byte and advances per operand, level reports the fill count.
 */

`timescale 1ns/1ps

module byte_fifo import spi_target_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic  clock_in,
    input  logic  arst_n,

    input  byte_t opcode,
    input  logic  opcode_valid,
    input  byte_t operand,
    input  logic  operand_valid,

    output byte_t response,
    output logic  response_valid
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    byte_t            mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;

    logic             is_push;
    logic             is_pop;
    logic             is_level;
    logic             full;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    assign is_push  = opcode_valid && (opcode == OP_FIFO_PUSH);
    assign is_pop   = opcode_valid && (opcode == OP_FIFO_POP);
    assign is_level = opcode_valid && (opcode == OP_FIFO_LEVEL);

    assign full  = (fill == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty = (fill == '0);

    // Overflow and underflow leave the FIFO untouched
    assign do_push = is_push && operand_valid && !full;
    assign do_pop  = is_pop && operand_valid && !empty;

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop never share an opcode
            if (do_push) begin
                fill <= fill + 1'b1;
            end else if (do_pop) begin
                fill <= fill - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clock_in) begin
        if (do_push) begin
            mem[wr_ptr] <= operand;
        end
    end

    always_comb begin
        response_valid = is_push || is_pop || is_level;
        if (is_pop && !empty) begin
            response = mem[rd_ptr];
        end else if (is_level) begin
            response = 8'(fill);
        end else begin
            response = 8'h00;
        end
    end

endmodule

// File: source/crc8_unit.sv
/*
 * CRC-8 unit
 * Accumulates operand bytes into a CRC-8 (poly 0x07, init 0x00, MSB
 * first, no reflection, no final XOR). Separate opcodes feed bytes,
 * read the checksum and clear it.
 */

`timescale 1ns/1ps

module crc8_unit import spi_target_pkg::*; (
    input  logic  clock_in,
    input  logic  arst_n,

    input  byte_t opcode,
    input  logic  opcode_valid,
    input  byte_t operand,
    input  logic  operand_valid,

    output byte_t response,
    output logic  response_valid
);

    byte_t crc;

    logic  is_feed;
    logic  is_read;
    logic  is_clear;

    // One byte through the polynomial, bit 7 first
    function automatic byte_t crc8_next(byte_t crc_in, byte_t data);
        byte_t c;
        c = crc_in ^ data;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) begin
                c = (c << 1) ^ 8'h07;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    assign is_feed  = opcode_valid && (opcode == OP_CRC_FEED);
    assign is_read  = opcode_valid && (opcode == OP_CRC_READ);
    assign is_clear = opcode_valid && (opcode == OP_CRC_CLEAR);

    // Clear holds at zero for the rest of its transaction
    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            crc <= 8'h00;
        end else if (operand_valid) begin
            if (is_feed) begin
                crc <= crc8_next(crc, operand);
            end else if (is_clear) begin
                crc <= 8'h00;
            end
        end
    end

    assign response_valid = is_feed || is_read || is_clear;
    assign response       = is_read ? crc : 8'h00;

endmodule

// File: source/spi_target_top.sv
/*
 * SPI target top level
 * Connects the SPI framing block to the register bank, byte FIFO and
 * CRC-8 unit. Response priority follows the port order on the
 * framing block.
 */

`timescale 1ns/1ps

module spi_target_top import spi_target_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic clock_in,
    input  logic arst_n,
    input  logic spi_select,
    input  logic spi_clock,
    input  logic spi_data_in,
    output logic spi_data_out
);

    byte_t          opcode;
    byte_t          operand;
    logic           opcode_valid;
    logic           operand_valid;
    operand_count_t operand_count;

    byte_t          reg_response;
    byte_t          fifo_response;
    byte_t          crc_response;
    logic           reg_response_valid;
    logic           fifo_response_valid;
    logic           crc_response_valid;

    spi_peripheral u_spi_peripheral (
        .clock_in         (clock_in),
        .arst_n           (arst_n),
        .spi_select       (spi_select),
        .spi_clock        (spi_clock),
        .spi_data_in      (spi_data_in),
        .spi_data_out     (spi_data_out),
        .opcode           (opcode),
        .operand          (operand),
        .opcode_valid     (opcode_valid),
        .operand_valid    (operand_valid),
        .operand_count    (operand_count),
        .response_1       (reg_response),
        .response_2       (fifo_response),
        .response_3       (crc_response),
        .response_1_valid (reg_response_valid),
        .response_2_valid (fifo_response_valid),
        .response_3_valid (crc_response_valid)
    );

    register_bank u_register_bank (
        .clock_in       (clock_in),
        .arst_n         (arst_n),
        .opcode         (opcode),
        .opcode_valid   (opcode_valid),
        .operand        (operand),
        .operand_valid  (operand_valid),
        .operand_count  (operand_count),
        .response       (reg_response),
        .response_valid (reg_response_valid)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_byte_fifo (
        .clock_in       (clock_in),
        .arst_n         (arst_n),
        .opcode         (opcode),
        .opcode_valid   (opcode_valid),
        .operand        (operand),
        .operand_valid  (operand_valid),
        .response       (fifo_response),
        .response_valid (fifo_response_valid)
    );

    crc8_unit u_crc8_unit (
        .clock_in       (clock_in),
        .arst_n         (arst_n),
        .opcode         (opcode),
        .opcode_valid   (opcode_valid),
        .operand        (operand),
        .operand_valid  (operand_valid),
        .response       (crc_response),
        .response_valid (crc_response_valid)
    );

endmodule

// File: verification/spi_target_tb.sv
/*
 * SPI target testbench
 * Drives the SPI pins as a mode 0 controller, keeps reference models of
 * the register bank, byte FIFO and CRC-8 unit, and compares every reply
 * byte against the expected value. A watchdog bounds the run time.
 */

`timescale 1ns/1ps

module spi_target_tb import spi_target_pkg::*; ();

    localparam int CLOCK_PERIOD_NS      = 100;
    localparam int RESET_CYCLES         = 16;
    localparam int HALF_PERIOD_CYCLES   = 8;
    localparam int FIFO_DEPTH           = 16;
    localparam int NUM_TRANSACTIONS     = 20;
    localparam int MAX_TRANSACTION_BITS = 168;
    localparam int WATCHDOG_NS          =
        NUM_TRANSACTIONS * MAX_TRANSACTION_BITS * 16 * CLOCK_PERIOD_NS * 2;

    typedef byte_t byte_q_t[$];

    logic        clock_in;
    logic        arst_n;
    logic        spi_select;
    logic        spi_clock;
    logic        spi_data_in;
    logic        spi_data_out;

    // Reference state
    byte_t       model_regs [8];
    byte_q_t     model_fifo;
    byte_t       model_crc;

    byte_q_t     exp_q;
    byte_q_t     exp_op_q;
    byte_q_t     act_q;
    int          checks_done;
    logic [31:0] lfsr_state;

    spi_target_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clock_in     (clock_in),
        .arst_n       (arst_n),
        .spi_select   (spi_select),
        .spi_clock    (spi_clock),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out)
    );

    always #(CLOCK_PERIOD_NS / 2) clock_in = ~clock_in;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // Bitwise CRC-8 over polynomial 0x07 taking data bits MSB first
    function automatic byte_t crc8_reference(input byte_t crc, input byte_t data);
        byte_t r;
        logic  feedback;
        r = crc;
        for (int i = 7; i >= 0; i--) begin
            feedback = r[7] ^ data[i];
            r = {r[6:0], 1'b0};
            if (feedback) begin
                r = r ^ 8'h07;
            end
        end
        return r;
    endfunction

    // Reply expected during operand byte k of an opcode
    function automatic byte_t reference_reply(input byte_t op, input int k);
        logic [2:0] addr;
        addr = op[2:0] + 3'(k);
        if ((op & 8'hF8) == OP_REG_READ_BASE) begin
            return model_regs[addr];
        end else if (op == OP_FIFO_POP) begin
            return (model_fifo.size() > 0) ? model_fifo[0] : 8'h00;
        end else if (op == OP_FIFO_LEVEL) begin
            return 8'(model_fifo.size());
        end else if (op == OP_CRC_READ) begin
            return model_crc;
        end
        return 8'h00;
    endfunction

    task automatic apply_to_model(input byte_t op, input byte_t data, input int k);
        logic [2:0] addr;
        addr = op[2:0] + 3'(k);
        if ((op & 8'hF8) == OP_REG_WRITE_BASE) begin
            model_regs[addr] = data;
        end else if (op == OP_FIFO_PUSH && model_fifo.size() < FIFO_DEPTH) begin
            model_fifo.push_back(data);
        end else if (op == OP_FIFO_POP && model_fifo.size() > 0) begin
            model_fifo.delete(0);
        end else if (op == OP_CRC_FEED) begin
            model_crc = crc8_reference(model_crc, data);
        end else if (op == OP_CRC_CLEAR) begin
            model_crc = 8'h00;
        end
    endtask

    task automatic random_operands(input int count, output byte_q_t q);
        byte_t value;
        q = {};
        for (int n = 0; n < count; n++) begin
            for (int b = 0; b < 8; b++) begin
                value = {value[6:0], lfsr_state[0]};
                lfsr_state = lfsr_next(lfsr_state);
            end
            q.push_back(value);
        end
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clock_in);
        #1;
    endtask

    // Mode 0 controller that stops after bit_count bits
    task automatic spi_transaction(input byte_t op, input byte_q_t operands,
                                   input int bit_count);
        byte_t tx_byte;
        byte_t rx_byte;
        int    byte_idx;
        spi_select = 1'b0;
        wait_cycles(HALF_PERIOD_CYCLES);
        for (int n = 0; n < bit_count; n++) begin
            byte_idx = n / 8;
            tx_byte  = (byte_idx == 0) ? op : operands[byte_idx - 1];
            spi_data_in = tx_byte[7 - (n % 8)];
            wait_cycles(HALF_PERIOD_CYCLES);
            // Reply bit is sampled just before the rising edge
            rx_byte = {rx_byte[6:0], spi_data_out};
            spi_clock = 1'b1;
            wait_cycles(HALF_PERIOD_CYCLES);
            spi_clock = 1'b0;
            if (byte_idx > 0 && (n % 8) == 7) begin
                act_q.push_back(rx_byte);
            end
        end
        spi_data_in = 1'b0;
        wait_cycles(HALF_PERIOD_CYCLES);
        spi_select = 1'b1;
        wait_cycles(HALF_PERIOD_CYCLES);
    endtask

    task automatic run_transaction(input byte_t op, input byte_q_t operands);
        for (int k = 0; k < operands.size(); k++) begin
            exp_q.push_back(reference_reply(op, k));
            exp_op_q.push_back(op);
            apply_to_model(op, operands[k], k);
        end
        spi_transaction(op, operands, 8 + 8 * operands.size());
    endtask

    always @(posedge clock_in) begin : compare_replies
        byte_t expected;
        byte_t observed;
        byte_t op;
        if (act_q.size() > 0) begin
            assert (exp_q.size() > 0) else begin
                $display("reply byte captured with no expected value");
                $display("TEST FAILED");
                $fatal(1, "unexpected reply");
            end
            observed = act_q.pop_front();
            expected = exp_q.pop_front();
            op       = exp_op_q.pop_front();
            assert (observed == expected) else begin
                $display("[FAIL] spi_data_out opcode 0x%02h: expected 0x%02h, got 0x%02h",
                         op, expected, observed);
                $display("TEST FAILED");
                $fatal(1, "reply mismatch");
            end
            checks_done++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("simulation timed out");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        byte_q_t ops;
        clock_in    = 1'b0;
        arst_n      = 1'b0;
        spi_select  = 1'b1;
        spi_clock   = 1'b0;
        spi_data_in = 1'b0;
        checks_done = 0;
        lfsr_state  = 32'h6357_912c;
        model_crc   = 8'h00;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = 8'h00;
        end
        wait_cycles(RESET_CYCLES);
        arst_n = 1'b1;
        wait_cycles(HALF_PERIOD_CYCLES);

        // Reset values
        random_operands(8, ops);
        run_transaction(OP_REG_READ_BASE, ops);
        random_operands(1, ops);
        run_transaction(OP_FIFO_LEVEL, ops);
        run_transaction(OP_CRC_READ, ops);

        // Register burst wrapping past address 7
        random_operands(4, ops);
        run_transaction(OP_REG_WRITE_BASE | 8'h06, ops);
        random_operands(8, ops);
        run_transaction(OP_REG_READ_BASE | 8'h05, ops);

        // FIFO order and level
        random_operands(5, ops);
        run_transaction(OP_FIFO_PUSH, ops);
        random_operands(1, ops);
        run_transaction(OP_FIFO_LEVEL, ops);
        random_operands(5, ops);
        run_transaction(OP_FIFO_POP, ops);

        // FIFO overflow drops the last four pushes
        random_operands(20, ops);
        run_transaction(OP_FIFO_PUSH, ops);
        random_operands(1, ops);
        run_transaction(OP_FIFO_LEVEL, ops);
        random_operands(16, ops);
        run_transaction(OP_FIFO_POP, ops);

        // Empty pop where the head slot still holds an old byte
        random_operands(1, ops);
        run_transaction(OP_FIFO_POP, ops);

        // CRC across two feeds followed by a clear
        random_operands(6, ops);
        run_transaction(OP_CRC_FEED, ops);
        random_operands(5, ops);
        run_transaction(OP_CRC_FEED, ops);
        random_operands(1, ops);
        run_transaction(OP_CRC_READ, ops);
        run_transaction(OP_CRC_CLEAR, ops);
        run_transaction(OP_CRC_READ, ops);

        // Unknown opcode and a write cut off halfway through its first operand
        random_operands(4, ops);
        run_transaction(8'h7F, ops);
        random_operands(2, ops);
        spi_transaction(OP_REG_WRITE_BASE, ops, 12);
        random_operands(8, ops);
        run_transaction(OP_REG_READ_BASE, ops);

        while (act_q.size() != 0) begin
            @(posedge clock_in);
        end
        wait_cycles(2);
        if (exp_q.size() == 0 && checks_done > 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("expected replies were never received");
            $display("TEST FAILED");
            $fatal(1, "missing replies");
        end
    end

endmodule

// File: spi_target_top.f
common/spi_target_pkg.sv
spi_peripheral/spi_peripheral.sv
source/register_bank.sv
source/byte_fifo.sv
source/crc8_unit.sv
source/spi_target_top.sv
verification/spi_target_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the SPI target testbench with Verilator and runs it.
# The result is taken from the simulation log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module spi_target_tb \
    -f spi_target_top.f -Mdir obj_dir -o spi_target_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/spi_target_sim > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation did not complete, see sim.log"; exit 1; }
echo "Simulation passed"
